/* hw/rv_decode_pkg.sv */
package rv_decode_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int NUM_REGS   = 32;   // x0 included

   ////////////////////////////////////////
   // ISA encodings
   ////////////////////////////////////////
   typedef enum logic [6:0] {
      LOAD   = 7'b000_0011,
      STORE  = 7'b010_0011,
      OP     = 7'b011_0011,
      OP_IMM = 7'b001_0011,
      BRANCH = 7'b110_0011,
      JAL    = 7'b110_1111,
      JALR   = 7'b110_0111,
      LUI    = 7'b011_0111,
      AUIPC  = 7'b001_0111
   } opcode_e;

   typedef enum logic [2:0] {
      IMM_I,
      IMM_S,
      IMM_B,
      IMM_U,
      IMM_J
   } imm_fmt_e;

   // Operation class handed to execute
   typedef enum logic [2:0] {
      EX_ADD,      // Address or PC-relative add
      EX_ALU_R,
      EX_ALU_I,
      EX_BRANCH,
      EX_LUI,
      EX_JUMP
   } ex_op_e;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_PC4
   } wb_sel_e;

   typedef enum logic [3:0] {
      MEM_NONE,
      LB, LH, LW, LBU, LHU,
      SB, SH, SW
   } mem_op_e;

   ////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////
   // All-zero value is a bubble
   typedef struct packed {
      logic    op1_sel;   // PC instead of rs1
      logic    op2_sel;   // Immediate instead of rs2
      mem_op_e mem_op;
      wb_sel_e wb_sel;
      logic    reg_wr_en;
      logic    is_load;
      logic    is_store;
      logic    is_branch;
      logic    is_jump;
      ex_op_e  ex_op;
   } ctrl_t;

   typedef struct packed {
      logic [XLEN-1:0]       pc;
      logic [XLEN-1:0]       rs1_value;
      logic [XLEN-1:0]       rs2_value;
      logic [XLEN-1:0]       imm;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [2:0]            funct3;
      logic [6:0]            funct7;
      ctrl_t                 ctrl;
   } id_ex_t;

   // Write-back port into the register file
   typedef struct packed {
      logic                  en;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       data;
   } wb_port_t;

endpackage

/* hw/main_decoder.sv */
module main_decoder
   import rv_decode_pkg::*;
(
   input  opcode_e    opcode_i,
   input  logic [2:0] funct3_i,
   input  logic [6:0] funct7_i,
   output ctrl_t      ctrl_o,
   output imm_fmt_e   imm_fmt_o
);

   mem_op_e ld_op;
   mem_op_e st_op;
   logic    shift_ok;

   ////////////////////////////////////////
   // funct3 / funct7 qualifiers
   ////////////////////////////////////////
   always_comb begin
      case (funct3_i)
         3'b000:  ld_op = LB;
         3'b001:  ld_op = LH;
         3'b010:  ld_op = LW;
         3'b100:  ld_op = LBU;
         3'b101:  ld_op = LHU;
         default: ld_op = MEM_NONE;   // Reserved width
      endcase
   end

   always_comb begin
      case (funct3_i)
         3'b000:  st_op = SB;
         3'b001:  st_op = SH;
         3'b010:  st_op = SW;
         default: st_op = MEM_NONE;
      endcase
   end

   // SLLI needs funct7 zero, SRLI/SRAI allow bit 30 only
   always_comb begin
      case (funct3_i)
         3'b001:  shift_ok = (funct7_i == 7'b000_0000);
         3'b101:  shift_ok = (funct7_i == 7'b000_0000) || (funct7_i == 7'b010_0000);
         default: shift_ok = 1'b1;
      endcase
   end

   ////////////////////////////////////////
   // Main decode
   ////////////////////////////////////////
   always_comb begin
      ctrl_o    = '0;       // Bubble unless decoded below
      imm_fmt_o = IMM_I;
      case (opcode_i)
         LOAD: begin
            if (ld_op != MEM_NONE) begin
               ctrl_o.op2_sel   = 1'b1;
               ctrl_o.mem_op    = ld_op;
               ctrl_o.wb_sel    = WB_MEM;
               ctrl_o.reg_wr_en = 1'b1;
               ctrl_o.is_load   = 1'b1;
               ctrl_o.ex_op     = EX_ADD;
            end
         end
         STORE: begin
            imm_fmt_o = IMM_S;
            if (st_op != MEM_NONE) begin
               ctrl_o.op2_sel  = 1'b1;
               ctrl_o.mem_op   = st_op;
               ctrl_o.is_store = 1'b1;
               ctrl_o.ex_op    = EX_ADD;
            end
         end
         OP: begin
            ctrl_o.reg_wr_en = 1'b1;
            ctrl_o.ex_op     = EX_ALU_R;
         end
         OP_IMM: begin
            if (shift_ok) begin
               ctrl_o.op2_sel   = 1'b1;
               ctrl_o.reg_wr_en = 1'b1;
               ctrl_o.ex_op     = EX_ALU_I;
            end
         end
         BRANCH: begin
            imm_fmt_o        = IMM_B;
            ctrl_o.is_branch = 1'b1;   // Compares rs1 with rs2
            ctrl_o.ex_op     = EX_BRANCH;
         end
         JAL, JALR: begin
            imm_fmt_o        = (opcode_i == JAL) ? IMM_J : IMM_I;
            ctrl_o.op1_sel   = (opcode_i == JAL);   // JALR targets rs1 + imm
            ctrl_o.op2_sel   = 1'b1;
            ctrl_o.wb_sel    = WB_PC4;
            ctrl_o.reg_wr_en = 1'b1;
            ctrl_o.is_jump   = 1'b1;
            ctrl_o.ex_op     = EX_JUMP;
         end
         LUI: begin
            imm_fmt_o        = IMM_U;
            ctrl_o.op2_sel   = 1'b1;
            ctrl_o.reg_wr_en = 1'b1;
            ctrl_o.ex_op     = EX_LUI;
         end
         AUIPC: begin
            imm_fmt_o        = IMM_U;
            ctrl_o.op1_sel   = 1'b1;
            ctrl_o.op2_sel   = 1'b1;
            ctrl_o.reg_wr_en = 1'b1;
            ctrl_o.ex_op     = EX_ADD;
         end
         default: ;
      endcase
   end

endmodule

/* hw/imm_gen.sv */
module imm_gen
   import rv_decode_pkg::*;
(
   input  logic [31:7]     instr_i,   // Opcode bits not needed
   input  imm_fmt_e        fmt_i,
   output logic [XLEN-1:0] imm_o
);

   logic sign;

   assign sign = instr_i[31];

   always_comb begin
      case (fmt_i)
         IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
         IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
         // Halfword aligned offsets
         IMM_B: begin
            imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
         end
         IMM_U: imm_o = {instr_i[31:12], 12'b0};   // Upper 20 bits only
         IMM_J: begin
            imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
         end
         default: imm_o = '0;
      endcase
   end

endmodule

/* hw/regfile.sv */
module regfile
   import rv_decode_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  wb_port_t              wb_i,
   input  logic [REG_ADDR_W-1:0] rs1_i,
   input  logic [REG_ADDR_W-1:0] rs2_i,
   output logic [XLEN-1:0]       rs1_data_o,
   output logic [XLEN-1:0]       rs2_data_o
);

   logic [XLEN-1:0] regs [1:NUM_REGS-1];   // x0 has no storage
   logic            wr_valid;

   assign wr_valid = wb_i.en && (wb_i.rd != '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_valid) begin
         regs[wb_i.rd] <= wb_i.data;
      end
   end

   ////////////////////////////////////////
   // Read ports with write-through
   ////////////////////////////////////////
   function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (wr_valid && (wb_i.rd == addr)) begin
         return wb_i.data;   // Same-cycle write wins
      end
      return regs[addr];
   endfunction

   always_comb begin
      rs1_data_o = read_port(rs1_i);
      rs2_data_o = read_port(rs2_i);
   end

endmodule

/* hw/instruction_decode_stage.sv */
module instruction_decode_stage
   import rv_decode_pkg::*;
(
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  logic [XLEN-1:0] instr_i,
   input  logic [XLEN-1:0] pc_i,
   input  logic            stall_i,
   input  logic            busywait_i,
   input  logic            flush_i,
   input  wb_port_t        wb_i,      // From write-back stage
   output id_ex_t          id_ex_o,
   output logic            load_stall_o
);

   ////////////////////////////////////////
   // Field extraction
   ////////////////////////////////////////
   opcode_e               opcode;
   logic [REG_ADDR_W-1:0] rd;
   logic [REG_ADDR_W-1:0] rs1;
   logic [REG_ADDR_W-1:0] rs2;
   logic [2:0]            funct3;
   logic [6:0]            funct7;

   assign opcode = opcode_e'(instr_i[6:0]);
   assign rd     = instr_i[11:7];
   assign funct3 = instr_i[14:12];
   assign rs1    = instr_i[19:15];
   assign rs2    = instr_i[24:20];
   assign funct7 = instr_i[31:25];

   ctrl_t           ctrl;
   imm_fmt_e        imm_fmt;
   logic [XLEN-1:0] imm;
   logic [XLEN-1:0] rs1_value;
   logic [XLEN-1:0] rs2_value;

   main_decoder u_main_decoder (
      .opcode_i  (opcode),
      .funct3_i  (funct3),
      .funct7_i  (funct7),
      .ctrl_o    (ctrl),
      .imm_fmt_o (imm_fmt)
   );

   imm_gen u_imm_gen (
      .instr_i (instr_i[31:7]),
      .fmt_i   (imm_fmt),
      .imm_o   (imm)
   );

   regfile u_regfile (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wb_i       (wb_i),
      .rs1_i      (rs1),
      .rs2_i      (rs2),
      .rs1_data_o (rs1_value),
      .rs2_data_o (rs2_value)
   );

   ////////////////////////////////////////
   // Load-use hazard
   ////////////////////////////////////////
   id_ex_t id_ex_q;
   logic   uses_rs2;

   // Only R, S and B formats carry a real rs2
   always_comb begin
      case (opcode)
         OP, STORE, BRANCH: uses_rs2 = 1'b1;
         default:           uses_rs2 = 1'b0;
      endcase
   end

   // Load now in execute feeds a register read here
   assign load_stall_o = id_ex_q.ctrl.is_load && (id_ex_q.rd != '0) &&
                         ((id_ex_q.rd == rs1) || (uses_rs2 && (id_ex_q.rd == rs2)));

   ////////////////////////////////////////
   // ID/EX register
   ////////////////////////////////////////
   id_ex_t id_ex_d;
   logic   hold;

   assign hold = stall_i || busywait_i;

   always_comb begin
      id_ex_d.pc        = pc_i;
      id_ex_d.rs1_value = rs1_value;
      id_ex_d.rs2_value = rs2_value;
      id_ex_d.imm       = imm;
      id_ex_d.rd        = rd;
      id_ex_d.rs1       = rs1;
      id_ex_d.rs2       = rs2;
      id_ex_d.funct3    = funct3;
      id_ex_d.funct7    = funct7;
      id_ex_d.ctrl      = ctrl;
   end

   // Reset, then flush, then hold
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         id_ex_q <= '0;
      end else if (flush_i) begin
         id_ex_q <= '0;      // Bubble, overrides a stall
      end else if (!hold) begin
         id_ex_q <= id_ex_d;
      end
   end

   assign id_ex_o = id_ex_q;

endmodule

/* verification/tb_clock.sv */
module tb_clock (
   output logic clk_o,
   output logic rst_n_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;   // 40 ns period
   end

   // Low over 3 rising edges, released on a falling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

/* verification/decode_props.sv */
module decode_props
   import rv_decode_pkg::*;
(
   input logic   clk_i,
   input logic   rst_n_i,
   input logic   stall_i,
   input logic   busywait_i,
   input logic   flush_i,
   input id_ex_t id_ex_i,
   input logic   load_stall_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // Hazard only with a writing load sitting in execute
   stall_has_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      load_stall_i |-> (id_ex_i.ctrl.is_load && id_ex_i.ctrl.reg_wr_en &&
                        (id_ex_i.ctrl.wb_sel == WB_MEM)))
      else $error("load_stall_o high without a load in ID/EX");

   flush_gives_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_i |=> (id_ex_i.ctrl == '0))
      else $error("ID/EX control not cleared after flush");

   hold_keeps_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ((stall_i || busywait_i) && !flush_i) |=> $stable(id_ex_i))
      else $error("ID/EX changed during a hold");

   ctrl_known: assert property (@(posedge clk_i)
      rst_n_i |-> !$isunknown(id_ex_i.ctrl))
      else $error("Unknown control bit in ID/EX");

endmodule

bind instruction_decode_stage decode_props u_decode_props (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .stall_i      (stall_i),
   .busywait_i   (busywait_i),
   .flush_i      (flush_i),
   .id_ex_i      (id_ex_o),
   .load_stall_i (load_stall_o)
);

/* verification/decode_tb.sv */
module decode_tb
   import rv_decode_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   logic            clk;
   logic            rst_n;
   logic [XLEN-1:0] instr;
   logic [XLEN-1:0] pc;
   logic            stall;
   logic            busywait;
   logic            flush;
   wb_port_t        wb;
   id_ex_t          id_ex;
   logic            load_stall;

   logic [XLEN-1:0] shadow [NUM_REGS];   // Register model
   logic [31:0]     rng_state = 32'hcd2c8d41;
   id_ex_t          exp_q;
   logic            exp_valid = 1'b0;
   string           test_name = "reset";
   opcode_e         op_table [9] = '{LOAD, STORE, OP, OP_IMM, BRANCH, JAL, JALR, LUI, AUIPC};

   tb_clock u_clock (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   instruction_decode_stage dut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .instr_i      (instr),
      .pc_i         (pc),
      .stall_i      (stall),
      .busywait_i   (busywait),
      .flush_i      (flush),
      .wb_i         (wb),
      .id_ex_o      (id_ex),
      .load_stall_o (load_stall)
   );

   ////////////////////////////////////////
   // Random and encoding helpers
   ////////////////////////////////////////
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [4:0] rd,
                                              input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [6:0] f7);
      return {f7, rs2, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] rand_instr();
      logic [31:0] sel;
      logic [31:0] fields;
      opcode_e     op;
      sel    = next_rand();
      fields = next_rand();
      op     = op_table[sel % 32'd9];
      if ((op == OP_IMM) && fields[0]) begin
         fields[31:25] = fields[1] ? 7'h20 : 7'h00;   // Legal shift encodings
      end
      return {fields[31:7], op};
   endfunction

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic id_ex_t ref_decode(input logic [31:0] ins, input logic [31:0] p,
                                         input logic [XLEN-1:0] regs [NUM_REGS]);
      id_ex_t     r;
      logic [2:0] f3;
      logic [6:0] f7;
      logic       legal;
      r  = '0;
      f3 = ins[14:12];
      f7 = ins[31:25];
      r.pc        = p;
      r.rd        = ins[11:7];
      r.rs1       = ins[19:15];
      r.rs2       = ins[24:20];
      r.funct3    = f3;
      r.funct7    = f7;
      r.rs1_value = regs[ins[19:15]];
      r.rs2_value = regs[ins[24:20]];
      r.imm       = {{20{ins[31]}}, ins[31:20]};   // I format unless overridden
      case (ins[6:0])
         LOAD: begin
            legal = (f3 != 3'd3) && (f3 < 3'd6);
            r.ctrl.mem_op    = (f3 == 3'd0) ? LB : (f3 == 3'd1) ? LH : (f3 == 3'd2) ? LW :
                               (f3 == 3'd4) ? LBU : (f3 == 3'd5) ? LHU : MEM_NONE;
            r.ctrl.op2_sel   = legal;
            r.ctrl.wb_sel    = legal ? WB_MEM : WB_ALU;
            r.ctrl.reg_wr_en = legal;
            r.ctrl.is_load   = legal;
         end
         STORE: begin
            r.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            if (f3 < 3'd3) begin
               r.ctrl.mem_op   = (f3 == 3'd0) ? SB : (f3 == 3'd1) ? SH : SW;
               r.ctrl.op2_sel  = 1'b1;
               r.ctrl.is_store = 1'b1;
            end
         end
         OP: begin
            r.ctrl.reg_wr_en = 1'b1;
            r.ctrl.ex_op     = EX_ALU_R;
         end
         OP_IMM: begin
            legal = !((f3 == 3'd1) && (f7 != 7'h00)) &&
                    !((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
            r.ctrl.op2_sel   = legal;
            r.ctrl.reg_wr_en = legal;
            r.ctrl.ex_op     = legal ? EX_ALU_I : EX_ADD;
         end
         BRANCH: begin
            r.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            r.ctrl.is_branch = 1'b1;
            r.ctrl.ex_op     = EX_BRANCH;
         end
         JAL, JALR: begin
            if (ins[6:0] == JAL) begin
               r.imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            r.ctrl.op1_sel   = (ins[6:0] == JAL);   // PC-relative target
            r.ctrl.op2_sel   = 1'b1;
            r.ctrl.wb_sel    = WB_PC4;
            r.ctrl.reg_wr_en = 1'b1;
            r.ctrl.is_jump   = 1'b1;
            r.ctrl.ex_op     = EX_JUMP;
         end
         LUI, AUIPC: begin
            r.imm            = {ins[31:12], 12'h000};
            r.ctrl.op1_sel   = (ins[6:0] == AUIPC);
            r.ctrl.op2_sel   = 1'b1;
            r.ctrl.reg_wr_en = 1'b1;
            r.ctrl.ex_op     = (ins[6:0] == LUI) ? EX_LUI : EX_ADD;
         end
         default: ;   // Bubble
      endcase
      return r;
   endfunction

   function automatic logic load_use_ref(input id_ex_t q, input logic [31:0] ins);
      logic reads_rs2;
      reads_rs2 = (ins[6:0] == OP) || (ins[6:0] == STORE) || (ins[6:0] == BRANCH);
      return q.ctrl.is_load && (q.rd != 5'd0) &&
             ((q.rd == ins[19:15]) || (reads_rs2 && (q.rd == ins[24:20])));
   endfunction

   ////////////////////////////////////////
   // Checking
   ////////////////////////////////////////
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         abort_run("Mismatch between DUT and expected value");
      end
   endtask

   task automatic compare_fields(input id_ex_t e, input id_ex_t a);
      check_val({test_name, ".ctrl"}, 32'(e.ctrl), 32'(a.ctrl));
      check_val({test_name, ".pc"}, e.pc, a.pc);
      check_val({test_name, ".rs1_value"}, e.rs1_value, a.rs1_value);
      check_val({test_name, ".rs2_value"}, e.rs2_value, a.rs2_value);
      check_val({test_name, ".imm"}, e.imm, a.imm);
      check_val({test_name, ".rd"}, 32'(e.rd), 32'(a.rd));
      check_val({test_name, ".rs1"}, 32'(e.rs1), 32'(a.rs1));
      check_val({test_name, ".rs2"}, 32'(e.rs2), 32'(a.rs2));
      check_val({test_name, ".funct3"}, 32'(e.funct3), 32'(a.funct3));
      check_val({test_name, ".funct7"}, 32'(e.funct7), 32'(a.funct7));
   endtask

   // Output seen here is still the one from the previous edge
   always @(posedge clk) begin
      if (exp_valid) begin
         compare_fields(exp_q, id_ex);
         check_val({test_name, ".load_stall"}, 32'(load_use_ref(exp_q, instr)),
                   32'(load_stall));
      end
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
         end
         exp_q = '0;
      end else begin
         if (wb.en && (wb.rd != 5'd0)) begin
            shadow[wb.rd] = wb.data;   // Write-through for this decode
         end
         if (flush) begin
            exp_q = '0;
         end else if (!(stall || busywait)) begin
            exp_q = ref_decode(instr, pc, shadow);
         end
      end
      exp_valid = 1'b1;
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   task automatic step();
      @(negedge clk);
   endtask

   task automatic drive(input logic [31:0] ins, input logic [31:0] p);
      instr = ins;
      pc    = p;
      step();
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (rst_n !== 1'b1) begin
         if (n == 20) begin
            abort_run("Timed out waiting for reset to be released");
         end else begin
            @(posedge clk);
            n++;
         end
      end
   endtask

   task automatic hazard_probe(input logic [31:0] ld, input logic [31:0] nxt,
                               input logic exp_stall);
      drive(ld, pc + 32'd4);
      instr = nxt;
      #1;
      check_val({test_name, ".probe"}, 32'(exp_stall), 32'(load_stall));
      step();
   endtask

   initial begin
      logic [31:0] rnd;
      logic [31:0] lw5;
      logic [31:0] addi;
      id_ex_t      saved;
      instr    = '0;   // Opcode zero decodes to a bubble
      pc       = '0;
      stall    = 1'b0;
      busywait = 1'b0;
      flush    = 1'b0;
      wb       = '0;
      wait_reset_release();
      step();
      check_val("reset.ctrl", 32'h0, 32'(id_ex.ctrl));
      check_val("reset.load_stall", 32'h0, 32'(load_stall));

      test_name = "regfile";
      for (int r = 1; r < NUM_REGS; r++) begin
         wb = '{en: 1'b1, rd: 5'(r), data: next_rand()};
         step();
      end
      wb = '{en: 1'b1, rd: 5'd3, data: 32'hdead_beef};
      step();
      wb = '0;
      drive(make_instr(OP, 5'd1, 3'd0, 5'd3, 5'd0, 7'd0), 32'h100);
      check_val("regfile.readback", 32'hdead_beef, id_ex.rs1_value);
      wb = '{en: 1'b1, rd: 5'd0, data: 32'h1234_5678};
      drive(make_instr(OP, 5'd1, 3'd0, 5'd0, 5'd0, 7'd0), 32'h104);
      check_val("regfile.x0", 32'h0, id_ex.rs1_value);
      wb = '{en: 1'b1, rd: 5'd7, data: 32'hcafe_f00d};   // Same cycle as the read
      drive(make_instr(OP, 5'd2, 3'd0, 5'd1, 5'd7, 7'd0), 32'h108);
      check_val("regfile.bypass", 32'hcafe_f00d, id_ex.rs2_value);

      test_name = "random";
      for (int n = 0; n < 300; n++) begin
         rnd = next_rand();
         wb  = '{en: rnd[0], rd: rnd[5:1], data: next_rand()};
         rnd = next_rand();
         drive(rand_instr(), rnd & 32'hffff_fffc);
      end
      wb = '0;

      test_name = "load_use";
      lw5 = make_instr(LOAD, 5'd5, 3'd2, 5'd2, 5'd0, 7'd0);
      hazard_probe(lw5, make_instr(OP, 5'd6, 3'd0, 5'd5, 5'd1, 7'd0), 1'b1);
      hazard_probe(lw5, make_instr(STORE, 5'd4, 3'd2, 5'd1, 5'd5, 7'd0), 1'b1);
      hazard_probe(make_instr(LOAD, 5'd0, 3'd2, 5'd2, 5'd0, 7'd0),
                   make_instr(OP, 5'd6, 3'd0, 5'd0, 5'd0, 7'd0), 1'b0);
      hazard_probe(lw5, make_instr(OP_IMM, 5'd6, 3'd0, 5'd1, 5'd5, 7'd0), 1'b0);
      hazard_probe(lw5, make_instr(OP, 5'd6, 3'd0, 5'd1, 5'd2, 7'd0), 1'b0);

      test_name = "hold";
      addi  = make_instr(OP_IMM, 5'd9, 3'd0, 5'd3, 5'd12, 7'd0);
      saved = ref_decode(addi, 32'h300, shadow);   // No write-back pending here
      drive(addi, 32'h300);
      stall = 1'b1;
      drive(make_instr(LUI, 5'd8, 3'd5, 5'd9, 5'd9, 7'd3), 32'h304);
      compare_fields(saved, id_ex);
      stall    = 1'b0;
      busywait = 1'b1;
      drive(make_instr(JAL, 5'd1, 3'd2, 5'd4, 5'd6, 7'd9), 32'h308);
      compare_fields(saved, id_ex);
      busywait = 1'b0;
      drive(make_instr(BRANCH, 5'd2, 3'd1, 5'd3, 5'd4, 7'd0), 32'h30c);
      check_val("hold.release", 32'h30c, id_ex.pc);

      test_name = "flush";
      drive(make_instr(OP, 5'd10, 3'd0, 5'd1, 5'd2, 7'd0), 32'h400);
      stall = 1'b1;
      flush = 1'b1;   // Flush wins over stall
      drive(make_instr(JALR, 5'd1, 3'd0, 5'd4, 5'd0, 7'd0), 32'h404);
      check_val("flush.ctrl", 32'h0, 32'(id_ex.ctrl));
      stall = 1'b0;
      flush = 1'b0;
      step();
      step();

      $display("TEST OK");
      $finish;
   end

endmodule

/* list.f */
hw/rv_decode_pkg.sv
hw/main_decoder.sv
hw/imm_gen.sv
hw/regfile.sv
hw/instruction_decode_stage.sv
verification/tb_clock.sv
verification/decode_props.sv
verification/decode_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = decode_tb
FLIST = list.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
